/* hdl/exec_pkg.sv */
// shared types and sizes for the execution cluster, compiled before every module that uses them
package exec_pkg;

    // operand and result width
    localparam int data_w = 32;

    // tag width for matching results to requests
    localparam int tag_w = 4;

    // shift amount bits taken from src_b
    localparam int shamt_w = $clog2(data_w);

    // queue depths
    localparam int req_depth = 4;
    localparam int rsp_depth = 4;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        alu_op_e           op;
        logic [data_w-1:0] src_a;
        logic [data_w-1:0] src_b;
    } exec_req_t;

    // one result per request, same tag
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] value;
    } exec_rsp_t;

endpackage

/* hdl/fifo.sv */
// generic valid/ready queue with empty bypass, instantiated per payload type and depth
module fifo #(
    parameter type T = logic [31:0],
    parameter int unsigned DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    localparam int unsigned addr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned cnt_w = $clog2(DEPTH + 1);

    logic              push;
    logic              pop;
    logic              fwd_in;
    logic [addr_w-1:0] wptr_q;
    logic [addr_w-1:0] rptr_q;
    logic [addr_w-1:0] wptr_next;
    logic [addr_w-1:0] rptr_next;
    logic [cnt_w-1:0]  cnt_q;
    logic [cnt_w-1:0]  cnt_next;
    logic              empty_q;
    logic              ready_q;
    logic              valid_q;

    T mem [DEPTH];
    T data_out_q;
    T data_out_next;

    // wrap explicitly so non power of two depths work
    function automatic logic [addr_w-1:0] ptr_inc(input logic [addr_w-1:0] ptr);
        if (ptr == addr_w'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + addr_w'(1);
    endfunction

    assign push = in_valid & ready_q;
    assign pop  = out_valid & out_ready;

    assign wptr_next = push ? ptr_inc(wptr_q) : wptr_q;
    assign rptr_next = pop ? ptr_inc(rptr_q) : rptr_q;
    assign cnt_next  = cnt_q + cnt_w'(push) - cnt_w'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            cnt_q   <= '0;
            empty_q <= 1'b0;
        end else begin
            wptr_q  <= wptr_next;
            rptr_q  <= rptr_next;
            cnt_q   <= cnt_next;
            empty_q <= (cnt_next == '0);
        end
    end

    // flags from the updated occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            ready_q <= (cnt_next < cnt_w'(DEPTH));
            valid_q <= (cnt_next != '0);
        end
    end

    // new head is the entry being written when all older ones are gone
    assign fwd_in = push && (cnt_q == cnt_w'(pop));

    assign data_out_next = fwd_in ? in_data : mem[rptr_next];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr_q] <= in_data;
        end
        data_out_q <= data_out_next;
    end

    assign in_ready = ready_q;

    // empty last cycle, so pass the input straight through
    assign out_valid = empty_q ? in_valid : valid_q;
    assign out_data  = empty_q ? in_data : data_out_q;

endmodule

/* hdl/alu_stage.sv */
// single registered ALU stage between the request and result queues, one result per request
module alu_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  exec_pkg::exec_req_t req,
    output logic                out_valid,
    input  logic                out_ready,
    output exec_pkg::exec_rsp_t rsp
);

    import exec_pkg::*;

    logic               accept;
    logic [data_w-1:0]  result;
    logic [shamt_w-1:0] shamt;
    logic               valid_q;
    exec_rsp_t          rsp_q;

    // free or draining this cycle
    assign in_ready = !valid_q || out_ready;
    assign accept   = in_valid && in_ready;

    assign shamt = req.src_b[shamt_w-1:0];

    always_comb begin
        result = '0;
        unique case (req.op)
            op_add: begin
                result = req.src_a + req.src_b;
            end
            op_sub: begin
                result = req.src_a - req.src_b;
            end
            op_and: begin
                result = req.src_a & req.src_b;
            end
            op_or: begin
                result = req.src_a | req.src_b;
            end
            op_xor: begin
                result = req.src_a ^ req.src_b;
            end
            op_sll: begin
                result = req.src_a << shamt;
            end
            op_srl: begin
                result = req.src_a >> shamt;
            end
            op_slt: begin
                // signed compare, zero extended flag
                result = data_w'($signed(req.src_a) < $signed(req.src_b));
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    // result and tag together
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_q.tag   <= req.tag;
            rsp_q.value <= result;
        end
    end

    assign out_valid = valid_q;
    assign rsp       = rsp_q;

endmodule

/* hdl/exec_unit.sv */
// execution cluster top level, request queue into the ALU stage into the result queue
module exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  exec_pkg::exec_req_t req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output exec_pkg::exec_rsp_t rsp
);

    import exec_pkg::*;

    // request queue to ALU
    logic      alu_in_valid;
    logic      alu_in_ready;
    exec_req_t alu_req;

    // ALU to result queue
    logic      alu_out_valid;
    logic      alu_out_ready;
    exec_rsp_t alu_rsp;

    fifo #(
        .T     (exec_req_t),
        .DEPTH (req_depth)
    ) u_req_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (alu_in_valid),
        .out_ready (alu_in_ready),
        .out_data  (alu_req)
    );

    alu_stage u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (alu_in_valid),
        .in_ready  (alu_in_ready),
        .req       (alu_req),
        .out_valid (alu_out_valid),
        .out_ready (alu_out_ready),
        .rsp       (alu_rsp)
    );

    fifo #(
        .T     (exec_rsp_t),
        .DEPTH (rsp_depth)
    ) u_rsp_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (alu_out_valid),
        .in_ready  (alu_out_ready),
        .in_data   (alu_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

/* tests/exec_unit_sva.sv */
// handshake assertions for the execution cluster, bound into exec_unit by the bind below
module exec_unit_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input logic                req_ready,
    input exec_pkg::exec_req_t req,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input exec_pkg::exec_rsp_t rsp
);

    // stalled result must not move
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp_valid or rsp changed while stalled");

    // stalled request must not move
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("req_valid or req changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rsp_valid))
        else $error("rsp_valid is unknown");

    // registered ready starts low
    assert property (@(posedge clk) $rose(rst_n) |-> !req_ready)
        else $error("req_ready high in the first cycle after reset");

endmodule

bind exec_unit exec_unit_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

/* tests/exec_unit_tb.sv */
// directed testbench for the execution cluster, built and run by run.sh
module exec_unit_tb;

    import exec_pkg::*;

    localparam int max_accept = req_depth + 1 + rsp_depth;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    exec_req_t req;
    logic      rsp_valid;
    logic      rsp_ready;
    exec_rsp_t rsp;

    logic [31:0] rng_state = 32'h7de3940e;
    logic        seen_req_ready = 1'b0;
    logic        seen_rsp_valid = 1'b0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          accepted;
    // 0 holds rsp_ready low, 1 holds it high, 2 toggles at random
    int          ready_mode;
    exec_req_t   send_q[$];
    exec_rsp_t   exp_q[$];

    exec_unit i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // reference model from the opcode rules
    function automatic exec_rsp_t expected_rsp(input exec_req_t r);
        exec_rsp_t e;
        e.tag = r.tag;
        case (r.op)
            op_add: e.value = r.src_a + r.src_b;
            op_sub: e.value = r.src_a - r.src_b;
            op_and: e.value = r.src_a & r.src_b;
            op_or: e.value = r.src_a | r.src_b;
            op_xor: e.value = r.src_a ^ r.src_b;
            op_sll: e.value = r.src_a << r.src_b[4:0];
            op_srl: e.value = r.src_a >> r.src_b[4:0];
            op_slt: e.value = ($signed(r.src_a) < $signed(r.src_b)) ? data_w'(1) : '0;
            default: e.value = '0;
        endcase
        return e;
    endfunction

    function automatic exec_req_t make_req(input logic [tag_w-1:0] tag, input alu_op_e op,
                                           input logic [data_w-1:0] a,
                                           input logic [data_w-1:0] b);
        exec_req_t r;
        r.tag   = tag;
        r.op    = op;
        r.src_a = a;
        r.src_b = b;
        return r;
    endfunction

    function automatic exec_req_t random_req(input logic [tag_w-1:0] tag);
        logic [31:0] sel;
        sel = next_rand();
        return make_req(tag, alu_op_e'(sel[2:0]), next_rand(), next_rand());
    endfunction

    task automatic check_rsp(input string name, input exec_rsp_t expected,
                             input exec_rsp_t actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %h actual %h", $time, name, expected,
                     actual);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %b actual %b", $time, name, expected,
                     actual);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // score the handshakes of this edge, then drive the next inputs
    task automatic run_cycle();
        logic [31:0] r;
        exec_rsp_t   expected;
        @(posedge clk);
        seen_req_ready = req_ready;
        seen_rsp_valid = rsp_valid;
        if (req_valid && req_ready) begin
            exp_q.push_back(expected_rsp(req));
            void'(send_q.pop_front());
            accepted++;
        end
        if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Result with tag %h arrived at time %0t with nothing outstanding",
                         rsp.tag, $time);
                fail_cnt++;
            end else begin
                expected = exp_q.pop_front();
                check_rsp("rsp", expected, rsp);
            end
        end
        if (send_q.size() > 0) begin
            req_valid <= 1'b1;
            req       <= send_q[0];
        end else begin
            req_valid <= 1'b0;
        end
        r = next_rand();
        case (ready_mode)
            0: rsp_ready <= 1'b0;
            1: rsp_ready <= 1'b1;
            default: rsp_ready <= r[0];
        endcase
    endtask

    task automatic drain_all(input int limit, input string what);
        int n;
        n = 0;
        while ((send_q.size() > 0 || exp_q.size() > 0) && n < limit) begin
            run_cycle();
            n++;
        end
        if (send_q.size() > 0 || exp_q.size() > 0) begin
            $display("Timeout: %s still had %0d requests and %0d results pending after %0d cycles",
                     what, send_q.size(), exp_q.size(), limit);
            fail_cnt++;
        end
    endtask

    task automatic send_one(input exec_req_t r);
        send_q.push_back(r);
        drain_all(20, "single request");
    endtask

    task automatic finish_test(input string name, input int start);
        $display("%s finished with %0d errors", name, fail_cnt - start);
    endtask

    task automatic reset_behavior();
        int start;
        int n;
        start = fail_cnt;
        ready_mode = 1;
        run_cycle();
        check_bit("req_ready", 1'b0, seen_req_ready);
        check_bit("rsp_valid", 1'b0, seen_rsp_valid);
        n = 0;
        while (!seen_req_ready && n < 10) begin
            run_cycle();
            n++;
        end
        if (!seen_req_ready) begin
            $display("Timeout: req_ready did not rise after reset");
            fail_cnt++;
        end
        finish_test("reset", start);
    endtask

    task automatic opcode_sweep();
        int start;
        start = fail_cnt;
        ready_mode = 1;
        send_one(make_req(4'h0, op_add, 32'hffff_ffff, 32'h0000_0001));
        send_one(make_req(4'h1, op_add, 32'h1234_5678, 32'h1111_1111));
        send_one(make_req(4'h2, op_sub, 32'h0000_0000, 32'h0000_0001));
        send_one(make_req(4'h3, op_and, 32'hf0f0_ff00, 32'h3c3c_0ff0));
        send_one(make_req(4'h4, op_or, 32'hf0f0_ff00, 32'h3c3c_0ff0));
        send_one(make_req(4'h5, op_xor, 32'hf0f0_ff00, 32'h3c3c_0ff0));
        send_one(make_req(4'h6, op_sll, 32'h8000_0001, 32'h0000_0000));
        send_one(make_req(4'h7, op_sll, 32'h0000_0003, 32'h0000_001f));
        send_one(make_req(4'h8, op_srl, 32'h8000_0000, 32'h0000_001f));
        // only the low 5 bits count
        send_one(make_req(4'h9, op_srl, 32'hdead_beef, 32'hffff_ffe4));
        send_one(make_req(4'ha, op_slt, 32'hffff_ffff, 32'h0000_0001));
        send_one(make_req(4'hb, op_slt, 32'h0000_0001, 32'hffff_ffff));
        send_one(make_req(4'hc, op_slt, 32'h8000_0000, 32'h7fff_ffff));
        send_one(make_req(4'hd, op_slt, 32'h0000_0005, 32'h0000_0005));
        finish_test("opcodes", start);
    endtask

    task automatic stream_in_order();
        int start;
        start = fail_cnt;
        ready_mode = 1;
        for (int i = 0; i < 16; i++) begin
            send_q.push_back(random_req(4'(i)));
        end
        drain_all(100, "stream");
        finish_test("stream", start);
    endtask

    task automatic backpressure_limit();
        int start;
        int n;
        start = fail_cnt;
        ready_mode = 0;
        accepted = 0;
        for (int i = 0; i < 12; i++) begin
            send_q.push_back(random_req(4'(i)));
        end
        n = 0;
        while ((accepted == 0 || seen_req_ready) && n < 50) begin
            run_cycle();
            n++;
        end
        if (seen_req_ready) begin
            $display("Timeout: req_ready never fell while results were blocked");
            fail_cnt++;
        end
        repeat (5) run_cycle();
        check_bit("req_ready", 1'b0, seen_req_ready);
        if (accepted > max_accept) begin
            $display("%0d requests accepted while results were blocked, limit is %0d",
                     accepted, max_accept);
            fail_cnt++;
        end
        ready_mode = 1;
        drain_all(100, "back-pressure drain");
        repeat (3) run_cycle();
        finish_test("back-pressure", start);
    endtask

    task automatic random_ready_stream();
        int start;
        start = fail_cnt;
        ready_mode = 2;
        for (int i = 0; i < 40; i++) begin
            send_q.push_back(random_req(4'(i)));
        end
        drain_all(1000, "random ready stream");
        ready_mode = 1;
        repeat (4) run_cycle();
        finish_test("random ready", start);
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        ready_mode = 0;
        accepted   = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_behavior();
        opcode_sweep();
        stream_in_order();
        backpressure_limit();
        random_ready_stream();
        $display("%0d checks passed, %0d errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/exec_pkg.sv
hdl/fifo.sv
hdl/alu_stage.sv
hdl/exec_unit.sv
tests/exec_unit_sva.sv
tests/exec_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the execution cluster testbench with Verilator, run it, and check the log
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module exec_unit_tb \
    -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "Test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
